/* common/arm_pkg.sv */
package arm_pkg;

	// Widths that carry a meaning.
	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_idx_t;
	typedef logic [15:0] reg_mask_t;
	typedef logic [3:0]  flags_t;
	typedef logic [3:0]  cond_t;

	// Bit positions of the NZCV flags.
	localparam int FLAG_N = 3;
	localparam int FLAG_Z = 2;
	localparam int FLAG_C = 1;
	localparam int FLAG_V = 0;

	// Architectural condition field encodings.
	localparam cond_t COND_EQ = 4'h0;
	localparam cond_t COND_NE = 4'h1;
	localparam cond_t COND_CS = 4'h2;
	localparam cond_t COND_CC = 4'h3;
	localparam cond_t COND_MI = 4'h4;
	localparam cond_t COND_PL = 4'h5;
	localparam cond_t COND_VS = 4'h6;
	localparam cond_t COND_VC = 4'h7;
	localparam cond_t COND_HI = 4'h8;
	localparam cond_t COND_LS = 4'h9;
	localparam cond_t COND_GE = 4'hA;
	localparam cond_t COND_LT = 4'hB;
	localparam cond_t COND_GT = 4'hC;
	localparam cond_t COND_LE = 4'hD;
	localparam cond_t COND_AL = 4'hE;
	localparam cond_t COND_NV = 4'hF;

	// Data-processing opcodes in insn[24:21].
	localparam logic [3:0] ALU_AND = 4'h0;
	localparam logic [3:0] ALU_EOR = 4'h1;
	localparam logic [3:0] ALU_SUB = 4'h2;
	localparam logic [3:0] ALU_RSB = 4'h3;
	localparam logic [3:0] ALU_ADD = 4'h4;
	localparam logic [3:0] ALU_ADC = 4'h5;
	localparam logic [3:0] ALU_SBC = 4'h6;
	localparam logic [3:0] ALU_RSC = 4'h7;
	localparam logic [3:0] ALU_TST = 4'h8;
	localparam logic [3:0] ALU_TEQ = 4'h9;
	localparam logic [3:0] ALU_CMP = 4'hA;
	localparam logic [3:0] ALU_CMN = 4'hB;
	localparam logic [3:0] ALU_ORR = 4'hC;
	localparam logic [3:0] ALU_MOV = 4'hD;
	localparam logic [3:0] ALU_BIC = 4'hE;
	localparam logic [3:0] ALU_MVN = 4'hF;

	// Shift type in insn[6:5].
	localparam logic [1:0] SHIFT_LSL = 2'b00;
	localparam logic [1:0] SHIFT_LSR = 2'b01;
	localparam logic [1:0] SHIFT_ASR = 2'b10;
	localparam logic [1:0] SHIFT_ROR = 2'b11;

	// One instruction slot moving down the pipeline.
	typedef struct packed {
		logic  bubble;
		word_t pc;
		word_t insn;
	} issue_slot_t;

	// Registers and flags read and written by one instruction.
	typedef struct packed {
		logic      use_flags;
		reg_mask_t use_regs;
		logic      def_flags;
		reg_mask_t def_regs;
	} reg_usage_t;

endpackage

/* src/decode_latch.sv */
module decode_latch (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 flush,
	input  logic                 hold,
	input  arm_pkg::issue_slot_t in_slot,
	output arm_pkg::issue_slot_t held_slot
);

	// Only the bubble flag is cleared on reset or flush.
	// A bubble's pc and insn are never looked at downstream.
	always_ff @(posedge clk)
	begin
		if (!rst_n || flush)
		begin
			held_slot.bubble <= 1'b1;
		end
		else if (!hold)
		begin
			held_slot <= in_slot;
		end
		// Otherwise the slot replays to the decoders until it issues.
	end

endmodule

/* issue/reg_usage_decode.sv */
module reg_usage_decode (
	input  arm_pkg::word_t     insn,
	output arm_pkg::reg_usage_t usage
);

	// One-hot register bit, with the PC left out.
	function automatic arm_pkg::reg_mask_t reg_bit(input arm_pkg::reg_idx_t r);
		arm_pkg::reg_mask_t m;
		m = '0;
		if (r != 4'd15)
		begin
			m[r] = 1'b1;
		end
		return m;
	endfunction

	// Immediate shifts by zero pass the old carry (LSL) or rotate it in (RRX).
	function automatic logic shift_needs_carry(input logic [1:0] typ, input logic [4:0] amt);
		logic need;
		case (typ)
			arm_pkg::SHIFT_LSL: need = (amt == 5'd0);
			arm_pkg::SHIFT_LSR: need = 1'b0;
			arm_pkg::SHIFT_ASR: need = 1'b0;
			arm_pkg::SHIFT_ROR: need = (amt == 5'd0);
			default:            need = 1'b0;
		endcase
		return need;
	endfunction

	arm_pkg::cond_t    cond;
	arm_pkg::reg_idx_t rn;
	arm_pkg::reg_idx_t rd;
	arm_pkg::reg_idx_t rs;
	arm_pkg::reg_idx_t rm;
	logic [3:0]        alu_op;
	logic              cond_used;
	logic              flags_only;
	logic              no_rn;
	logic              carry_in_op;
	logic              base_wb;

	assign cond = insn[31:28];
	assign rn = insn[19:16];
	assign rd = insn[15:12];
	assign rs = insn[11:8];
	assign rm = insn[3:0];
	assign alu_op = insn[24:21];
	assign cond_used = (cond != arm_pkg::COND_AL) && (cond != arm_pkg::COND_NV);

	assign flags_only = (alu_op == arm_pkg::ALU_TST) || (alu_op == arm_pkg::ALU_TEQ) ||
		(alu_op == arm_pkg::ALU_CMP) || (alu_op == arm_pkg::ALU_CMN);
	assign no_rn = (alu_op == arm_pkg::ALU_MOV) || (alu_op == arm_pkg::ALU_MVN);
	assign carry_in_op = (alu_op == arm_pkg::ALU_ADC) || (alu_op == arm_pkg::ALU_SBC) ||
		(alu_op == arm_pkg::ALU_RSC);

	// Post-indexed transfers always write the base back.
	assign base_wb = insn[21] || !insn[24];

	always_comb
	begin
		usage = '0;
		casez (insn)
			// Multiply. Rd and Rn swap places compared to data processing.
			32'b????_0000_00??_????_????_????_1001_????:
			begin
				usage.use_flags = cond_used;
				usage.use_regs = (insn[21] ? reg_bit(rd) : '0) | reg_bit(rs) | reg_bit(rm);
				usage.def_flags = insn[20];
				usage.def_regs = reg_bit(rn);
			end
			// MRS reads the CPSR when Ps is clear.
			32'b????_0001_0?00_1111_????_0000_0000_0000:
			begin
				usage.use_flags = cond_used || !insn[22];
				usage.def_regs = reg_bit(rd);
			end
			// MSR, whole register and flag-only forms.
			32'b????_0001_0?10_1001_1111_0000_0000_????,
			32'b????_00?1_0?10_1000_1111_????_????_????:
			begin
				usage.use_flags = cond_used;
				usage.use_regs = insn[25] ? '0 : reg_bit(rm);
				usage.def_flags = 1'b1;
			end
			// Swap.
			32'b????_0001_0?00_????_????_0000_1001_????:
			begin
				usage.use_flags = cond_used;
				usage.use_regs = reg_bit(rn) | reg_bit(rm);
				usage.def_regs = reg_bit(rd);
			end
			// BX.
			32'b????_0001_0010_1111_1111_1111_0001_????:
			begin
				usage.use_flags = cond_used;
				usage.use_regs = reg_bit(rm);
			end
			// Halfword transfers with register and immediate offset.
			32'b????_000?_?0??_????_????_0000_1??1_????,
			32'b????_000?_?1??_????_????_????_1??1_????:
			begin
				usage.use_flags = cond_used;
				usage.use_regs = reg_bit(rn) | (insn[22] ? '0 : reg_bit(rm)) |
					(insn[20] ? '0 : reg_bit(rd));
				usage.def_regs = (insn[20] ? reg_bit(rd) : '0) | (base_wb ? reg_bit(rn) : '0);
			end
			// Data processing.
			32'b????_00??_????_????_????_????_????_????:
			begin
				usage.use_flags = cond_used || carry_in_op ||
					(!insn[25] && !insn[4] && shift_needs_carry(insn[6:5], insn[11:7]));
				usage.use_regs = (insn[25] ? '0 : (insn[4] ? (reg_bit(rs) | reg_bit(rm)) :
					reg_bit(rm))) | (no_rn ? '0 : reg_bit(rn));
				usage.def_flags = insn[20] || flags_only;
				usage.def_regs = flags_only ? '0 : reg_bit(rd);
			end
			// Undefined space inside the single data transfer encoding.
			32'b????_011?_????_????_????_????_???1_????:
			begin
				usage = '0;
			end
			// Single data transfer. I set means a register offset here.
			32'b????_01??_????_????_????_????_????_????:
			begin
				usage.use_flags = cond_used;
				usage.use_regs = reg_bit(rn) | (insn[25] ? reg_bit(rm) : '0) |
					(insn[20] ? '0 : reg_bit(rd));
				usage.def_regs = (insn[20] ? reg_bit(rd) : '0) | (base_wb ? reg_bit(rn) : '0);
			end
			// Block transfer. An S-bit load may restore the CPSR.
			32'b????_100?_????_????_????_????_????_????:
			begin
				usage.use_flags = cond_used;
				usage.use_regs = reg_bit(rn) | (insn[20] ? '0 : {1'b0, insn[14:0]});
				usage.def_flags = insn[22] && insn[20];
				usage.def_regs = (insn[21] ? reg_bit(rn) : '0) |
					(insn[20] ? {1'b0, insn[14:0]} : '0);
			end
			// Branch. The link form writes R14.
			32'b????_101?_????_????_????_????_????_????:
			begin
				usage.use_flags = cond_used;
				usage.def_regs = insn[24] ? reg_bit(4'd14) : '0;
			end
			// Coprocessor data transfer.
			32'b????_110?_????_????_????_????_????_????:
			begin
				usage.use_flags = cond_used;
				usage.use_regs = reg_bit(rn);
				usage.def_regs = insn[21] ? reg_bit(rn) : '0;
			end
			// Coprocessor data operation.
			32'b????_1110_????_????_????_????_???0_????:
			begin
				usage.use_flags = cond_used;
			end
			// Coprocessor register transfer. MRC to R15 loads the flags.
			32'b????_1110_????_????_????_????_???1_????:
			begin
				usage.use_flags = cond_used;
				usage.use_regs = insn[20] ? '0 : reg_bit(rd);
				usage.def_flags = insn[20] && (rd == 4'd15);
				usage.def_regs = insn[20] ? reg_bit(rd) : '0;
			end
			// SWI.
			32'b????_1111_????_????_????_????_????_????:
			begin
				usage.use_flags = cond_used;
			end
			default:
			begin
				usage = '0;
			end
		endcase
	end

endmodule

/* issue/cond_check.sv */
module cond_check (
	input  arm_pkg::cond_t  cond,
	input  arm_pkg::flags_t flags,
	output logic            cond_pass
);

	logic n;
	logic z;
	logic c;
	logic v;

	assign n = flags[arm_pkg::FLAG_N];
	assign z = flags[arm_pkg::FLAG_Z];
	assign c = flags[arm_pkg::FLAG_C];
	assign v = flags[arm_pkg::FLAG_V];

	always_comb
	begin
		case (cond)
			arm_pkg::COND_EQ: cond_pass = z;
			arm_pkg::COND_NE: cond_pass = !z;
			arm_pkg::COND_CS: cond_pass = c;
			arm_pkg::COND_CC: cond_pass = !c;
			arm_pkg::COND_MI: cond_pass = n;
			arm_pkg::COND_PL: cond_pass = !n;
			arm_pkg::COND_VS: cond_pass = v;
			arm_pkg::COND_VC: cond_pass = !v;
			arm_pkg::COND_HI: cond_pass = c && !z;
			arm_pkg::COND_LS: cond_pass = !c || z;
			arm_pkg::COND_GE: cond_pass = (n == v);
			arm_pkg::COND_LT: cond_pass = (n != v);
			arm_pkg::COND_GT: cond_pass = !z && (n == v);
			arm_pkg::COND_LE: cond_pass = z || (n != v);
			arm_pkg::COND_AL: cond_pass = 1'b1;
			// NV is treated as never on this core.
			default:          cond_pass = 1'b0;
		endcase
	end

endmodule

/* issue/issue_stage.sv */
module issue_stage #(
	parameter int SB_DEPTH = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stall,
	input  logic                 flush,
	input  arm_pkg::issue_slot_t held_slot,
	input  arm_pkg::reg_usage_t  usage,
	input  logic                 cond_pass,
	output logic                 hold,
	output arm_pkg::issue_slot_t out_slot
);

	// Entry 0 is the instruction now in execute. Higher entries are older.
	arm_pkg::reg_mask_t sb_regs [SB_DEPTH];
	logic               sb_flags [SB_DEPTH];

	arm_pkg::reg_mask_t busy_regs;
	logic               busy_flags;
	logic               waiting;
	logic               issue;

	// Union of every write still in flight.
	always_comb
	begin
		busy_regs = '0;
		busy_flags = 1'b0;
		for (int i = 0; i < SB_DEPTH; i++)
		begin
			busy_regs = busy_regs | sb_regs[i];
			busy_flags = busy_flags | sb_flags[i];
		end
	end

	assign waiting = !held_slot.bubble &&
		((|(usage.use_regs & busy_regs)) || (usage.use_flags && busy_flags));
	assign hold = stall || waiting;
	assign issue = !held_slot.bubble && !waiting && cond_pass && !flush;

	// Killed, held and flushed slots enter as empty entries.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < SB_DEPTH; i++)
			begin
				sb_regs[i] <= '0;
				sb_flags[i] <= 1'b0;
			end
		end
		else if (!stall)
		begin
			sb_regs[0] <= issue ? usage.def_regs : '0;
			sb_flags[0] <= issue && usage.def_flags;
			for (int i = 1; i < SB_DEPTH; i++)
			begin
				sb_regs[i] <= sb_regs[i - 1];
				sb_flags[i] <= sb_flags[i - 1];
			end
		end
	end

	// Output slot towards execute.
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_slot.bubble <= 1'b1;
		end
		else if (!stall)
		begin
			out_slot.bubble <= !issue;
			out_slot.pc <= held_slot.pc;
			out_slot.insn <= held_slot.insn;
		end
		else if (flush)
		begin
			out_slot.bubble <= 1'b1;
		end
	end

endmodule

/* src/arm_issue_top.sv */
module arm_issue_top #(
	parameter int SB_DEPTH = 2
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 stall,
	input  logic                 flush,
	input  arm_pkg::issue_slot_t in_slot,
	input  arm_pkg::flags_t      flags,
	output arm_pkg::issue_slot_t out_slot,
	output logic                 stall_fetch
);

	arm_pkg::issue_slot_t held_slot;
	arm_pkg::reg_usage_t  usage;
	logic                 cond_pass;
	logic                 hold;

	assign stall_fetch = hold;

	decode_latch decode_latch_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.hold      (hold),
		.in_slot   (in_slot),
		.held_slot (held_slot)
	);

	reg_usage_decode reg_usage_decode_i (
		.insn  (held_slot.insn),
		.usage (usage)
	);

	// Condition field sits in the top nibble.
	cond_check cond_check_i (
		.cond      (held_slot.insn[31:28]),
		.flags     (flags),
		.cond_pass (cond_pass)
	);

	issue_stage #(
		.SB_DEPTH (SB_DEPTH)
	) issue_stage_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.stall     (stall),
		.flush     (flush),
		.held_slot (held_slot),
		.usage     (usage),
		.cond_pass (cond_pass),
		.hold      (hold),
		.out_slot  (out_slot)
	);

endmodule

/* test/arm_issue_sva.sv */
module arm_issue_sva (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 stall,
	input logic                 flush,
	input logic                 hold,
	input arm_pkg::issue_slot_t out_slot
);

	timeunit 1ns;
	timeprecision 1ps;

	// Nothing is in flight when reset ends.
	property no_hold_after_reset;
		@(posedge clk) ($rose(rst_n) && !stall) |-> !hold;
	endproperty

	// A stalled output keeps its slot.
	property out_held_on_stall;
		@(posedge clk) (rst_n && stall && !flush) |=>
			($stable(out_slot.bubble) &&
			(out_slot.bubble || ($stable(out_slot.pc) && $stable(out_slot.insn))));
	endproperty

	// Flush kills whatever would have issued.
	property bubble_after_flush;
		@(posedge clk) (rst_n && flush) |=> out_slot.bubble;
	endproperty

	a_no_hold_after_reset: assert property (no_hold_after_reset)
		else $error("stall_fetch high right after reset");
	a_out_held_on_stall: assert property (out_held_on_stall)
		else $error("out_slot changed while stall was high");
	a_bubble_after_flush: assert property (bubble_after_flush)
		else $error("out_slot not a bubble after flush");

endmodule

bind issue_stage arm_issue_sva arm_issue_sva_i (
	.clk      (clk),
	.rst_n    (rst_n),
	.stall    (stall),
	.flush    (flush),
	.hold     (hold),
	.out_slot (out_slot)
);

/* test/tb_arm_issue.sv */
module tb_arm_issue;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int SB_DEPTH = 2;
	localparam int N_RANDOM = 400;
	localparam int N_DIRECTED = 60;
	localparam int STIM_COUNT = (N_RANDOM + N_DIRECTED) * (SB_DEPTH + 1);
	localparam int RESET_TIME = 4 * 20;

	logic                 clk;
	logic                 rst_n;
	logic                 stall;
	logic                 flush;
	arm_pkg::issue_slot_t in_slot;
	arm_pkg::flags_t      flags;
	arm_pkg::issue_slot_t out_slot;
	logic                 stall_fetch;

	integer         seed;
	int             error_count;
	bit             model_valid;
	arm_pkg::word_t next_pc;

	// Model state of the latch, the scoreboard and the output register.
	arm_pkg::issue_slot_t m_held;
	arm_pkg::issue_slot_t m_out;
	arm_pkg::reg_mask_t   m_sb_regs [SB_DEPTH];
	logic                 m_sb_flags [SB_DEPTH];

	arm_issue_top #(
		.SB_DEPTH (SB_DEPTH)
	) arm_issue_top_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.stall       (stall),
		.flush       (flush),
		.in_slot     (in_slot),
		.flags       (flags),
		.out_slot    (out_slot),
		.stall_fetch (stall_fetch)
	);

	always #10 clk = !clk;

	function automatic logic ref_cond_pass(input arm_pkg::cond_t c, input arm_pkg::flags_t f);
		logic n;
		logic z;
		logic cy;
		logic v;
		n = f[3];
		z = f[2];
		cy = f[1];
		v = f[0];
		case (c)
			4'h0: return z;
			4'h1: return !z;
			4'h2: return cy;
			4'h3: return !cy;
			4'h4: return n;
			4'h5: return !n;
			4'h6: return v;
			4'h7: return !v;
			4'h8: return cy && !z;
			4'h9: return !cy || z;
			4'hA: return n == v;
			4'hB: return n != v;
			4'hC: return !z && (n == v);
			4'hD: return z || (n != v);
			4'hE: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Usage for register-form data processing and B/BL only.
	function automatic arm_pkg::reg_usage_t ref_usage(input arm_pkg::word_t insn);
		arm_pkg::reg_usage_t u;
		logic [3:0]          op;
		logic                test_op;
		logic                cond_used;
		u = '0;
		op = insn[24:21];
		test_op = (op[3:2] == 2'b10);
		cond_used = (insn[31:28] != 4'hE) && (insn[31:28] != 4'hF);
		if (insn[27:25] == 3'b101)
		begin
			u.use_flags = cond_used;
			u.def_regs[14] = insn[24];
		end
		else
		begin
			u.use_flags = cond_used || (op == arm_pkg::ALU_ADC) || (op == arm_pkg::ALU_SBC) ||
				(op == arm_pkg::ALU_RSC) ||
				((insn[6:5] == arm_pkg::SHIFT_LSL) && (insn[11:7] == 5'd0)) ||
				((insn[6:5] == arm_pkg::SHIFT_ROR) && (insn[11:7] == 5'd0));
			u.use_regs[insn[3:0]] = 1'b1;
			if (op != arm_pkg::ALU_MOV && op != arm_pkg::ALU_MVN)
			begin
				u.use_regs[insn[19:16]] = 1'b1;
			end
			u.def_flags = insn[20] || test_op;
			if (!test_op)
			begin
				u.def_regs[insn[15:12]] = 1'b1;
			end
		end
		u.use_regs[15] = 1'b0;
		u.def_regs[15] = 1'b0;
		return u;
	endfunction

	// Waiting on the model scoreboard for the slot now in the latch.
	function automatic logic ref_waiting();
		arm_pkg::reg_usage_t u;
		arm_pkg::reg_mask_t  busy_r;
		logic                busy_f;
		busy_r = '0;
		busy_f = 1'b0;
		for (int i = 0; i < SB_DEPTH; i++)
		begin
			busy_r = busy_r | m_sb_regs[i];
			busy_f = busy_f | m_sb_flags[i];
		end
		u = ref_usage(m_held.insn);
		if (m_held.bubble)
		begin
			return 1'b0;
		end
		return (|(u.use_regs & busy_r)) || (u.use_flags && busy_f);
	endfunction

	function automatic arm_pkg::issue_slot_t ref_next_out(input arm_pkg::issue_slot_t cur,
		input arm_pkg::issue_slot_t held, input logic iss, input logic rst, input logic stl,
		input logic fl);
		arm_pkg::issue_slot_t nxt;
		nxt = cur;
		if (!rst)
		begin
			nxt.bubble = 1'b1;
		end
		else if (!stl)
		begin
			nxt = held;
			nxt.bubble = !iss;
		end
		else if (fl)
		begin
			nxt.bubble = 1'b1;
		end
		return nxt;
	endfunction

	// Steps the model on each rising edge and compares once the DUT has settled.
	always @(posedge clk)
	begin
		arm_pkg::reg_usage_t u;
		logic                hold_now;
		logic                iss;
		logic                exp_hold;
		u = ref_usage(m_held.insn);
		hold_now = stall || ref_waiting();
		iss = !m_held.bubble && !ref_waiting() && ref_cond_pass(m_held.insn[31:28], flags) &&
			!flush;
		m_out = ref_next_out(m_out, m_held, iss, rst_n, stall, flush);
		if (!rst_n)
		begin
			for (int i = 0; i < SB_DEPTH; i++)
			begin
				m_sb_regs[i] = '0;
				m_sb_flags[i] = 1'b0;
			end
		end
		else if (!stall)
		begin
			for (int i = SB_DEPTH - 1; i > 0; i--)
			begin
				m_sb_regs[i] = m_sb_regs[i - 1];
				m_sb_flags[i] = m_sb_flags[i - 1];
			end
			m_sb_regs[0] = iss ? u.def_regs : '0;
			m_sb_flags[0] = iss && u.def_flags;
		end
		if (!rst_n || flush)
		begin
			m_held.bubble = 1'b1;
		end
		else if (!hold_now)
		begin
			m_held = in_slot;
		end
		if (!rst_n)
		begin
			model_valid = 1'b1;
		end
		#5;
		if (model_valid)
		begin
			exp_hold = stall || ref_waiting();
			assert (out_slot.bubble === m_out.bubble)
			else
			begin
				$display("FAILED %0t out_slot.bubble got %0b expected %0b", $time,
					out_slot.bubble, m_out.bubble);
				error_count++;
			end
			if (!m_out.bubble)
			begin
				assert (out_slot.pc === m_out.pc && out_slot.insn === m_out.insn)
				else
				begin
					$display("FAILED %0t out_slot.pc/insn got %h/%h expected %h/%h", $time,
						out_slot.pc, out_slot.insn, m_out.pc, m_out.insn);
					error_count++;
				end
			end
			assert (stall_fetch === exp_hold)
			else
			begin
				$display("FAILED %0t stall_fetch got %0b expected %0b", $time,
					stall_fetch, exp_hold);
				error_count++;
			end
		end
	end

	function automatic arm_pkg::word_t make_dp(input logic [3:0] c, input logic [3:0] op,
		input logic s, input logic [3:0] rn, input logic [3:0] rd, input logic [4:0] amt,
		input logic [1:0] typ, input logic [3:0] rm);
		// Compare-class opcodes without S would be MRS, MSR or BX.
		return {c, 3'b000, op, s || (op[3:2] == 2'b10), rn, rd, amt, typ, 1'b0, rm};
	endfunction

	function automatic arm_pkg::word_t make_branch(input logic [3:0] c, input logic link,
		input logic [23:0] offs);
		return {c, 3'b101, link, offs};
	endfunction

	// Presents one instruction and waits until fetch may move on.
	task automatic send(input arm_pkg::word_t insn, input arm_pkg::flags_t f, output int waits);
		@(negedge clk);
		in_slot.bubble = 1'b0;
		in_slot.pc = next_pc;
		in_slot.insn = insn;
		flags = f;
		next_pc = next_pc + 32'd4;
		waits = 0;
		#1;
		while (stall_fetch)
		begin
			waits++;
			@(negedge clk);
			#1;
		end
	endtask

	task automatic idle(input int n);
		repeat (n)
		begin
			@(negedge clk);
			in_slot.bubble = 1'b1;
		end
	endtask

	task automatic stall_pulse(input int n);
		@(negedge clk);
		stall = 1'b1;
		in_slot.bubble = 1'b1;
		repeat (n - 1) @(negedge clk);
		@(negedge clk);
		stall = 1'b0;
	endtask

	task automatic flush_pulse();
		@(negedge clk);
		flush = 1'b1;
		in_slot.bubble = 1'b1;
		@(negedge clk);
		flush = 1'b0;
	endtask

	task automatic check_waits(input int got, input int expected, input string what);
		assert (got == expected)
		else
		begin
			$display("FAILED %0t %s wait cycles got %0d expected %0d", $time, what,
				got, expected);
			error_count++;
		end
	endtask

	initial
	begin
		#(STIM_COUNT * 40 + RESET_TIME);
		$display("Watchdog expired before the stimulus finished, errors: %0d", error_count);
		$display("Test failed");
		$finish;
	end

	initial
	begin
		int             w;
		logic [31:0]    r;
		arm_pkg::word_t insn;
		clk = 1'b0;
		rst_n = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		in_slot = '0;
		in_slot.bubble = 1'b1;
		flags = '0;
		seed = 32'h7938;
		next_pc = 32'h0000_0100;
		error_count = 0;
		model_valid = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		assert (out_slot.bubble === 1'b1)
		else
		begin
			$display("FAILED %0t out_slot.bubble got %0b expected 1", $time, out_slot.bubble);
			error_count++;
		end
		assert (stall_fetch === 1'b0)
		else
		begin
			$display("FAILED %0t stall_fetch got %0b expected 0", $time, stall_fetch);
			error_count++;
		end

		// Independent instructions flow without waiting.
		idle(SB_DEPTH + 1);
		for (int i = 0; i < 8; i++)
		begin
			send(make_dp(4'hE, arm_pkg::ALU_ADD, 1'b0, 4'd8, i[3:0], 5'd1, 2'b00, 4'd9), 4'h0, w);
			check_waits(w, 0, "independent");
		end

		// Register producer and consumer, then a PC-only consumer.
		idle(SB_DEPTH + 1);
		send(make_dp(4'hE, arm_pkg::ALU_ADD, 1'b0, 4'd8, 4'd1, 5'd1, 2'b00, 4'd9), 4'h0, w);
		send(make_dp(4'hE, arm_pkg::ALU_ADD, 1'b0, 4'd1, 4'd2, 5'd1, 2'b00, 4'd9), 4'h0, w);
		send(make_dp(4'hE, arm_pkg::ALU_ADD, 1'b0, 4'd8, 4'd5, 5'd1, 2'b00, 4'd9), 4'h0, w);
		check_waits(w, SB_DEPTH, "register hazard");
		idle(SB_DEPTH + 1);
		send(make_dp(4'hE, arm_pkg::ALU_ADD, 1'b0, 4'd8, 4'd15, 5'd1, 2'b00, 4'd9), 4'h0, w);
		send(make_dp(4'hE, arm_pkg::ALU_MOV, 1'b0, 4'd0, 4'd4, 5'd1, 2'b00, 4'd15), 4'h0, w);
		send(make_dp(4'hE, arm_pkg::ALU_ADD, 1'b0, 4'd8, 4'd5, 5'd1, 2'b00, 4'd9), 4'h0, w);
		check_waits(w, 0, "PC consumer");

		// Flag producer against a conditional, a carry shift and a plain consumer.
		for (int k = 0; k < 3; k++)
		begin
			idle(SB_DEPTH + 1);
			send(make_dp(4'hE, arm_pkg::ALU_ADD, 1'b1, 4'd8, 4'd1, 5'd1, 2'b00, 4'd9), 4'h4, w);
			if (k == 0)
			begin
				insn = make_dp(4'h0, arm_pkg::ALU_ADD, 1'b0, 4'd8, 4'd2, 5'd1, 2'b00, 4'd9);
			end
			else if (k == 1)
			begin
				insn = make_dp(4'hE, arm_pkg::ALU_MOV, 1'b0, 4'd0, 4'd2, 5'd0, 2'b11, 4'd9);
			end
			else
			begin
				insn = make_dp(4'hE, arm_pkg::ALU_ADD, 1'b0, 4'd8, 4'd2, 5'd1, 2'b00, 4'd9);
			end
			send(insn, 4'h4, w);
			send(make_dp(4'hE, arm_pkg::ALU_ADD, 1'b0, 4'd8, 4'd5, 5'd1, 2'b00, 4'd9), 4'h4, w);
			check_waits(w, (k == 2) ? 0 : SB_DEPTH, "flag hazard");
		end

		// Stall and flush around pending instructions.
		send(make_dp(4'hE, arm_pkg::ALU_SUB, 1'b0, 4'd8, 4'd3, 5'd2, 2'b01, 4'd9), 4'h0, w);
		stall_pulse(3);
		send(make_dp(4'hE, arm_pkg::ALU_ORR, 1'b0, 4'd3, 4'd6, 5'd2, 2'b01, 4'd9), 4'h0, w);
		flush_pulse();
		send(make_dp(4'hE, arm_pkg::ALU_EOR, 1'b0, 4'd8, 4'd7, 5'd2, 2'b01, 4'd9), 4'h0, w);
		idle(SB_DEPTH + 1);

		// Random mix over all condition codes and a few registers.
		for (int i = 0; i < N_RANDOM; i++)
		begin
			r = $random(seed);
			if (r[31:28] == 4'd0)
			begin
				stall_pulse(int'(r[1:0]) + 1);
			end
			else if (r[31:27] == 5'b00010)
			begin
				flush_pulse();
			end
			else if (r[26:24] == 3'd0)
			begin
				send(make_branch(r[3:0], r[4], r[23:0]), r[8:5], w);
			end
			else
			begin
				insn = make_dp(r[3:0], r[7:4], r[8], {r[10] & r[9], r[10:9]} == 3'b111 ?
					4'd15 : {2'b00, r[10:9]}, {2'b00, r[12:11]}, r[13] ? 5'd0 : r[18:14],
					r[20:19], {2'b00, r[22:21]});
				r = $random(seed);
				send(insn, r[3:0], w);
			end
		end
		idle(SB_DEPTH + 2);

		$display("Checks finished with %0d errors", error_count);
		if (error_count == 0)
		begin
			$display("Test completed successfully");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* verilog.f */
common/arm_pkg.sv
src/decode_latch.sv
issue/reg_usage_decode.sv
issue/cond_check.sv
issue/issue_stage.sv
src/arm_issue_top.sv
test/arm_issue_sva.sv
test/tb_arm_issue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_arm_issue
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
